// File: src.f
src/pitch_pkg.sv
src/frame_window.sv
src/overlap_store.sv
src/frame_sequencer.sv
src/pitch_core.sv
verif/pitch_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the overlap-add testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pitch_core_tb \
    -f src.f --Mdir obj_dir -o pitch_sim

./obj_dir/pitch_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    exit 0
else
    exit 1
fi

// File: verif/pitch_cases.txt
// src_base dst_base speed length max_delay expected_writes, all hex
// A line of all ones ends the list
000100 004000 8 40 0 40
000800 006000 8 40 c 40
001000 008000 4 30 3 50
002000 00a000 b 50 5 38
003000 00c000 1 20 0 90
004000 00e000 f 25 10 18
005000 010000 3 0a 2 08
006000 012000 b 50 0 38
007000 014000 4 30 f 50
7ff000 000010 7 10 1 10
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff

// File: verif/pitch_core_tb.sv
// pitch_core testbench with clock, reset, memory model, case loop, reference model and checks
`timescale 1ns/1ps

module pitch_core_tb;
    localparam int max_cases = 16;
    localparam int case_cols = 6;
    localparam logic [31:0] lfsr_seed = 32'h509db1ab;

    logic i_clk = 1'b0;
    logic i_rst;
    logic start;
    logic [pitch_pkg::addr_width-1:0] src_base;
    logic [pitch_pkg::addr_width-1:0] dst_base;
    logic [pitch_pkg::speed_width-1:0] speed;
    logic done;
    logic mem_read;
    logic mem_write;
    logic [pitch_pkg::addr_width-1:0] mem_addr;
    logic [pitch_pkg::word_width-1:0] mem_writedata;
    logic [pitch_pkg::word_width-1:0] mem_readdata;
    logic mem_finished;

    logic [31:0] case_mem [max_cases*case_cols];
    logic [31:0] mem_model [int];
    logic [31:0] exp_rd_q [$];
    logic [31:0] exp_wr_q [$];
    logic [31:0] delay_state, data_state, draw;
    logic [31:0] held_data;
    logic [pitch_pkg::addr_width-1:0] held_addr;
    logic held_read, pending, expect_drop, done_prev;
    int cycles, cycle_limit, done_count, write_count, req_count, max_delay, wait_cnt;

    pitch_core dut0 (.*);

    always #50 i_clk = ~i_clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            v = {v[30:0], st[0]};
        end
    endtask

    // Triangular weight scaled down by 8 and cut to one sample
    function automatic logic [15:0] weigh(input logic [15:0] sample, input int k);
        int w;
        int p;
        w = (k < 8) ? k + 1 : 16 - k;
        p = $signed(sample) * w;
        p = p >>> 3;
        return p[15:0];
    endfunction

    function automatic int frame_count(input int len, input int spd);
        if (len < 16) return 0;
        return (len - 16) / spd + 1;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic respond();
        if (held_read) begin
            if (exp_rd_q.size() == 0) begin
                fail_run("the core read more words than expected");
            end else begin
                check_value("read address", held_addr, exp_rd_q.pop_front());
                mem_readdata <= mem_model.exists(held_addr) ? mem_model[held_addr] : 32'h0;
            end
        end else if (exp_wr_q.size() == 0) begin
            fail_run("the core wrote more words than expected");
        end else begin
            check_value("write address", held_addr, dst_base + write_count);
            check_value("write data", held_data, exp_wr_q.pop_front());
            mem_model[held_addr] = held_data;
            write_count++;
        end
        mem_finished <= 1'b1;
    endtask

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) fail_run("the run did not finish in time");
        if (!i_rst) begin
            if (done && done_prev) fail_run("done stayed high for more than one cycle");
            if (done) done_count <= done_count + 1;
            done_prev <= done;
        end
    end

    // Memory slave sees the values from before the edge
    always @(posedge i_clk) begin
        if (!i_rst) begin
            if (mem_finished) begin
                mem_finished <= 1'b0;
                pending = 1'b0;
                expect_drop = 1'b1;
            end else if (expect_drop) begin
                check_value("request after finished", {mem_read, mem_write}, 2'b00);
                expect_drop = 1'b0;
            end else begin
                if (!pending && (mem_read || mem_write)) begin
                    if (req_count == 0) check_value("first request read", mem_read, 1'b1);
                    req_count++;
                    held_read = mem_read;
                    held_addr = mem_addr;
                    held_data = mem_writedata;
                    take_bits(delay_state, 8, draw);
                    wait_cnt = draw % (max_delay + 1);
                    pending = 1'b1;
                end
                if (pending) begin
                    check_value("mem_read", mem_read, held_read);
                    check_value("mem_write", mem_write, !held_read);
                    check_value("mem_addr", mem_addr, held_addr);
                    if (!held_read) check_value("mem_writedata", mem_writedata, held_data);
                    if (wait_cnt == 0) respond();
                    else wait_cnt--;
                end
            end
        end
    end

    initial begin
        int n;
        int len;
        int spd;
        int base;
        int frames;
        int outputs;
        int k;
        logic [31:0] w;
        logic [15:0] left;
        logic [15:0] right;
        i_rst = 1'b1;
        start = 1'b0;
        src_base = '0;
        dst_base = '0;
        speed = 4'd1;
        mem_finished = 1'b0;
        mem_readdata = '0;
        cycles = 0;
        done_count = 0;
        done_prev = 1'b0;
        pending = 1'b0;
        expect_drop = 1'b0;
        max_delay = 0;
        req_count = 0;
        delay_state = lfsr_seed;
        for (int i = 0; i < max_cases * case_cols; i++) case_mem[i] = '1;
        $readmemh("verif/pitch_cases.txt", case_mem);
        cycle_limit = 64; // Reset and slack
        n = 0;
        while (n < max_cases && case_mem[n*case_cols] != 32'hffffffff) begin
            len = case_mem[n*case_cols+3];
            outputs = (frame_count(len, case_mem[n*case_cols+2]) + 1) * 8;
            cycle_limit += (len + 1 + outputs) * (case_mem[n*case_cols+4] + 3) * 2 + 16;
            n++;
        end

        repeat (16) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);
        check_value("done after reset", done, 1'b0);
        check_value("mem_read after reset", mem_read, 1'b0);
        check_value("mem_write after reset", mem_write, 1'b0);

        for (int c = 0; c < n; c++) begin
            base = case_mem[c*case_cols][22:0];
            spd = case_mem[c*case_cols+2];
            len = case_mem[c*case_cols+3];
            max_delay = case_mem[c*case_cols+4];
            frames = frame_count(len, spd);
            outputs = (frames + 1) * 8;
            check_value("write count in case file", outputs, case_mem[c*case_cols+5]);

            // Source data restarts from the seed in every job
            mem_model.delete();
            mem_model[base] = {len[22:0], 9'h0};
            data_state = lfsr_seed;
            for (int a = 1; a <= len; a++) begin
                take_bits(data_state, 32, w);
                mem_model[base + a] = w;
            end
            exp_rd_q.delete();
            exp_wr_q.delete();
            exp_rd_q.push_back(base);
            for (int f = 0; f < frames; f++) begin
                for (int i = 0; i < 16; i++) exp_rd_q.push_back(base + 1 + f * spd + i);
            end
            for (int j = 0; j < outputs; j++) begin
                left = '0;
                right = '0;
                for (int f = 0; f < frames; f++) begin
                    k = j - 8 * f;
                    if (k >= 0 && k < 16) begin
                        w = mem_model[base + 1 + f * spd + k];
                        left = left + weigh(w[31:16], k);
                        right = right + weigh(w[15:0], k);
                    end
                end
                exp_wr_q.push_back({left, right});
            end
            write_count = 0;
            req_count = 0;

            @(posedge i_clk);
            src_base <= base[22:0];
            dst_base <= case_mem[c*case_cols+1][22:0];
            speed <= spd[3:0];
            start <= 1'b1;
            @(posedge i_clk);
            start <= 1'b0;
            while (done_count < c + 1) @(posedge i_clk);
            repeat (2) @(posedge i_clk);
            check_value("done pulses", done_count, c + 1);
            check_value("write count", write_count, outputs);
            check_value("reads left over", exp_rd_q.size(), 0);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: src/pitch_core.sv
// Overlap-add time-stretch core: sequencer, window stage and accumulation store
`timescale 1ns/1ps

module pitch_core (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             start,
    input  logic [pitch_pkg::addr_width-1:0]  src_base,
    input  logic [pitch_pkg::addr_width-1:0]  dst_base,
    input  logic [pitch_pkg::speed_width-1:0] speed,
    output logic                             done,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic [pitch_pkg::addr_width-1:0]  mem_addr,
    output logic [pitch_pkg::word_width-1:0]  mem_writedata,
    input  logic [pitch_pkg::word_width-1:0]  mem_readdata,
    input  logic                             mem_finished
);
    logic                             win_valid;
    logic [pitch_pkg::index_width-1:0] win_index;
    logic [pitch_pkg::word_width-1:0]  win_word;
    logic                             acc_valid;
    logic [pitch_pkg::index_width-1:0] acc_index;
    logic [pitch_pkg::word_width-1:0]  acc_word;
    logic                             clear;
    logic                             shift;
    logic [pitch_pkg::index_width-1:0] rd_index;
    logic [pitch_pkg::word_width-1:0]  rd_word;

    frame_sequencer seq0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .start(start), .src_base(src_base), .dst_base(dst_base), .speed(speed), .done(done),
        .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_writedata(mem_writedata), .mem_readdata(mem_readdata),
        .mem_finished(mem_finished),
        .win_valid(win_valid), .win_index(win_index), .win_word(win_word),
        .clear(clear), .shift(shift), .rd_index(rd_index), .rd_word(rd_word)
    );

    frame_window win0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .win_valid(win_valid), .win_index(win_index), .win_word(win_word),
        .acc_valid(acc_valid), .acc_index(acc_index), .acc_word(acc_word)
    );

    overlap_store store0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .clear(clear), .acc_valid(acc_valid), .acc_index(acc_index), .acc_word(acc_word),
        .shift(shift), .rd_index(rd_index), .rd_word(rd_word)
    );

endmodule

// File: src/frame_sequencer.sv
// Job FSM: header read, frame reads, half writes, final flush and done strobe
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             start,
    input  logic [pitch_pkg::addr_width-1:0]  src_base,
    input  logic [pitch_pkg::addr_width-1:0]  dst_base,
    input  logic [pitch_pkg::speed_width-1:0] speed,
    output logic                             done,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic [pitch_pkg::addr_width-1:0]  mem_addr,
    output logic [pitch_pkg::word_width-1:0]  mem_writedata,
    input  logic [pitch_pkg::word_width-1:0]  mem_readdata,
    input  logic                             mem_finished,
    output logic                             win_valid,
    output logic [pitch_pkg::index_width-1:0] win_index,
    output logic [pitch_pkg::word_width-1:0]  win_word,
    output logic                             clear,
    output logic                             shift,
    output logic [pitch_pkg::index_width-1:0] rd_index,
    input  logic [pitch_pkg::word_width-1:0]  rd_word
);
    pitch_pkg::job_state_t state;
    logic [pitch_pkg::index_width-1:0] word_cnt;
    logic last_word; // 16th read finished, window stage still busy
    logic [pitch_pkg::speed_width-1:0] speed_q;
    logic [pitch_pkg::addr_width-1:0] length, hdr_len;
    logic [pitch_pkg::addr_width-1:0] ana_off, ana_next, span;
    logic [pitch_pkg::addr_width-1:0] frame_ptr, out_addr, speed_ext;
    logic fin, raise_rd, raise_wr, half_end, more_frames;

    assign fin = (mem_read || mem_write) && mem_finished;
    assign hdr_len = mem_readdata[pitch_pkg::word_width-1 -: pitch_pkg::addr_width];
    assign speed_ext = {{(pitch_pkg::addr_width-pitch_pkg::speed_width){1'b0}}, speed_q};
    assign ana_next = ana_off + speed_ext;
    assign span = length - ana_next;
    // Next frame fits when at least window_size words remain
    assign more_frames = (ana_next <= length) && (|span[pitch_pkg::addr_width-1:pitch_pkg::index_width]);
    assign half_end = &word_cnt[pitch_pkg::index_width-2:0];
    assign raise_rd = (state == pitch_pkg::read_frame) && !mem_read && !last_word;
    assign raise_wr = (state == pitch_pkg::write_half || state == pitch_pkg::flush) && !mem_write;

    assign win_valid = (state == pitch_pkg::read_frame) && mem_read && mem_finished;
    assign win_index = word_cnt;
    assign win_word = mem_readdata;
    assign clear = (state == pitch_pkg::idle) && start;
    assign shift = (state == pitch_pkg::write_half) && fin && half_end;
    assign rd_index = word_cnt;
    assign done = (state == pitch_pkg::finish);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= pitch_pkg::idle;
            mem_read <= 1'b0;
            mem_write <= 1'b0;
            word_cnt <= '0;
            last_word <= 1'b0;
        end else begin
            case (state)
                pitch_pkg::idle: begin
                    if (start) begin
                        state <= pitch_pkg::read_header;
                        mem_read <= 1'b1;
                        word_cnt <= '0;
                        last_word <= 1'b0;
                    end
                end
                pitch_pkg::read_header: begin
                    if (fin) begin
                        mem_read <= 1'b0;
                        // Too short for one frame, only the zero tail goes out
                        if (|hdr_len[pitch_pkg::addr_width-1:pitch_pkg::index_width]) begin
                            state <= pitch_pkg::read_frame;
                        end else begin
                            state <= pitch_pkg::flush;
                        end
                    end
                end
                pitch_pkg::read_frame: begin
                    if (fin) begin
                        mem_read <= 1'b0;
                        word_cnt <= word_cnt + 1'b1;
                        if (&word_cnt) last_word <= 1'b1;
                    end else if (raise_rd) begin
                        mem_read <= 1'b1;
                    end else if (last_word) begin
                        last_word <= 1'b0; // Last weighted word has landed
                        state <= pitch_pkg::write_half;
                    end
                end
                pitch_pkg::write_half, pitch_pkg::flush: begin
                    if (fin) begin
                        mem_write <= 1'b0;
                        if (half_end) begin
                            word_cnt <= '0;
                            if (state == pitch_pkg::flush) begin
                                state <= pitch_pkg::finish;
                            end else if (more_frames) begin
                                state <= pitch_pkg::read_frame;
                            end else begin
                                state <= pitch_pkg::flush;
                            end
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end else if (raise_wr) begin
                        mem_write <= 1'b1;
                    end
                end
                pitch_pkg::finish: state <= pitch_pkg::idle;
                default: state <= pitch_pkg::idle;
            endcase
        end
    end

    // Addresses, write data and job parameters
    always_ff @(posedge i_clk) begin
        if (clear) begin
            mem_addr <= src_base; // Header word
            speed_q <= speed;
            out_addr <= dst_base;
            ana_off <= '0;
        end
        if (state == pitch_pkg::read_header && fin) begin
            length <= hdr_len;
            frame_ptr <= mem_addr + 1'b1;
        end
        if (raise_rd) mem_addr <= frame_ptr + {{(pitch_pkg::addr_width-pitch_pkg::index_width){1'b0}}, word_cnt};
        if (raise_wr) begin
            mem_addr <= out_addr;
            mem_writedata <= rd_word;
        end
        if (shift) begin
            ana_off <= ana_next;
            frame_ptr <= frame_ptr + speed_ext;
        end
        if (mem_write && fin) out_addr <= out_addr + 1'b1;
    end

    a_one_request: assert property (@(posedge i_clk) disable iff (i_rst)
        !(mem_read && mem_write));

    // Request held unchanged until finished
    a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        ((mem_read || mem_write) && !mem_finished) |=>
            ($stable(mem_read) && $stable(mem_write) && $stable(mem_addr)
             && $stable(mem_writedata)));

    a_speed_nonzero: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == pitch_pkg::idle && start) |-> (speed != '0));

endmodule

// File: src/overlap_store.sv
// Overlap-add accumulation store of one frame, shifted by half a frame per hop
`timescale 1ns/1ps

module overlap_store (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             clear,
    input  logic                             acc_valid,
    input  logic [pitch_pkg::index_width-1:0] acc_index,
    input  logic [pitch_pkg::word_width-1:0]  acc_word,
    input  logic                             shift,
    input  logic [pitch_pkg::index_width-1:0] rd_index,
    output logic [pitch_pkg::word_width-1:0]  rd_word
);
    logic [pitch_pkg::word_width-1:0] entry [pitch_pkg::window_size];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 0; i < pitch_pkg::window_size; i++) begin
                entry[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < pitch_pkg::window_size; i++) begin
                entry[i] <= '0;
            end
        end else if (shift) begin
            // Upper half becomes the overlap for the next frame
            for (int i = 0; i < pitch_pkg::synth_hop; i++) begin
                entry[i] <= entry[i+pitch_pkg::synth_hop];
                entry[i+pitch_pkg::synth_hop] <= '0;
            end
        end else if (acc_valid) begin
            // Per channel add, wraps at sample width
            for (int c = 0; c < pitch_pkg::word_width / pitch_pkg::sample_width; c++) begin
                entry[acc_index][c*pitch_pkg::sample_width +: pitch_pkg::sample_width] <=
                    entry[acc_index][c*pitch_pkg::sample_width +: pitch_pkg::sample_width]
                    + acc_word[c*pitch_pkg::sample_width +: pitch_pkg::sample_width];
            end
        end
    end

    assign rd_word = entry[rd_index];

    // Sequencer only shifts once the window stage has drained
    a_shift_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        !(shift && acc_valid));

endmodule

// File: src/frame_window.sv
// Triangular window stage, both channels of one word, one cycle latency
`timescale 1ns/1ps

module frame_window (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             win_valid,
    input  logic [pitch_pkg::index_width-1:0] win_index,
    input  logic [pitch_pkg::word_width-1:0]  win_word,
    output logic                             acc_valid,
    output logic [pitch_pkg::index_width-1:0] acc_index,
    output logic [pitch_pkg::word_width-1:0]  acc_word
);
    logic [pitch_pkg::index_width:0] weight;
    logic [pitch_pkg::word_width-1:0] weighted;

    assign weight = pitch_pkg::window_weight(win_index);

    // Left in the upper half, right in the lower half
    for (genvar ch = 0; ch < pitch_pkg::word_width / pitch_pkg::sample_width; ch++) begin : g_chan
        logic signed [pitch_pkg::sample_width-1:0] sample;
        logic signed [pitch_pkg::sample_width+pitch_pkg::index_width+1:0] prod;
        logic signed [pitch_pkg::sample_width+pitch_pkg::index_width+1:0] scaled;

        assign sample = win_word[ch*pitch_pkg::sample_width +: pitch_pkg::sample_width];
        assign prod = sample * $signed({1'b0, weight});
        assign scaled = prod >>> pitch_pkg::window_shift;
        assign weighted[ch*pitch_pkg::sample_width +: pitch_pkg::sample_width] =
            scaled[pitch_pkg::sample_width-1:0]; // Truncate to sample width
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) acc_valid <= 1'b0;
        else acc_valid <= win_valid;
    end

    always_ff @(posedge i_clk) begin
        if (win_valid) begin
            acc_index <= win_index;
            acc_word <= weighted;
        end
    end

endmodule

// File: src/pitch_pkg.sv
// Shared sizes, sequencer state type and triangular window weight
package pitch_pkg;

    // Memory geometry
    localparam int addr_width = 23;
    localparam int word_width = 32;
    localparam int sample_width = 16; // One channel, signed

    // Frame geometry
    localparam int window_size = 16;
    localparam int synth_hop = 8;     // Half of window_size
    localparam int index_width = 4;
    localparam int speed_width = 4;
    localparam int window_shift = 3;

    typedef enum logic [2:0] {
        idle,
        read_header,
        read_frame,
        write_half,
        flush,
        finish
    } job_state_t;

    // Triangular weight, rises 1..8 over the first half and falls 8..1 over the second
    function automatic logic [index_width:0] window_weight(
        input logic [index_width-1:0] k
    );
        logic [index_width:0] w;
        if (k[index_width-1]) begin
            w = {1'b1, {index_width{1'b0}}} - {1'b0, k}; // 16 - k
        end else begin
            w = {1'b0, k} + 1'b1;
        end
        return w;
    endfunction

endpackage
